// ==== tb.f ====
reg_bus_pkg.sv
capture_pkg.sv
host_bus_bridge.sv
trigger_ctrl.sv
glitch_gen.sv
capture_top.sv
capture_chk.sv
capture_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module capture_tb -f tb.f -o capture_sim

# assertion errors must not end the run before the testbench reports them
out=$(./obj_dir/capture_sim +verilator+error+limit+100 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Simulation PASSED"

// ==== capture_tb.sv ====
// testbench for the capture front end covering host bus register access, trigger and glitch stimulus
`timescale 1ns/100ps
`default_nettype none

module capture_tb;

	localparam int TIMEOUT_CYCLES = 6000; // tests need about 4000

	logic                   clk_usb;
	logic                   arst_n_i;
	logic [7:0]             usb_addr_i;
	reg_bus_pkg::reg_data_t usb_data_i;
	reg_bus_pkg::reg_data_t usb_data_o;
	logic                   usb_data_oe_o;
	logic                   usb_rdn_i;
	logic                   usb_wrn_i;
	logic                   usb_cen_i;
	logic                   usb_alen_i;
	logic [3:0]             target_io_i;
	logic                   trigger_o;
	logic                   glitch_o;
	logic                   armed_led_o;

	logic [31:0] rng_state;
	int unsigned cycle_count = 0;

	capture_top DUT (
		.clk_usb       (clk_usb),
		.arst_n_i      (arst_n_i),
		.usb_addr_i    (usb_addr_i),
		.usb_data_i    (usb_data_i),
		.usb_data_o    (usb_data_o),
		.usb_data_oe_o (usb_data_oe_o),
		.usb_rdn_i     (usb_rdn_i),
		.usb_wrn_i     (usb_wrn_i),
		.usb_cen_i     (usb_cen_i),
		.usb_alen_i    (usb_alen_i),
		.target_io_i   (target_io_i),
		.trigger_o     (trigger_o),
		.glitch_o      (glitch_o),
		.armed_led_o   (armed_led_o)
	);

	always #20 clk_usb = ~clk_usb; // 40 ns period

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic compare_byte(input string name, input reg_bus_pkg::reg_data_t expected,
			input reg_bus_pkg::reg_data_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %02h, got %02h",
				$time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	// n rising edges, then 2 ns into the cycle
	task automatic step(input int n);
		repeat (n) @(posedge clk_usb);
		#2;
	endtask

	task automatic select_chip(input logic en);
		usb_cen_i = ~en;
		step(4);
	endtask

	task automatic set_addr(input reg_bus_pkg::reg_addr_t a);
		usb_addr_i = {2'(next_random()), a}; // top bits are don't care
		usb_alen_i = 1'b0;
		step(5);
		usb_alen_i = 1'b1;
		step(5);
	endtask

	task automatic write_byte(input reg_bus_pkg::reg_data_t d);
		usb_data_i = d;
		usb_wrn_i  = 1'b0;
		step(5);
		usb_wrn_i  = 1'b1;
		step(5);
	endtask

	task automatic read_byte(output reg_bus_pkg::reg_data_t d);
		usb_rdn_i = 1'b0;
		step(5);
		d = usb_data_o; // end of the low phase
		if (usb_data_oe_o !== 1'b1) begin
			$display("usb_data_oe_o is not driven at the end of a read at %0t ns", $time);
			stop_with_failure();
		end
		usb_rdn_i = 1'b1;
		step(5);
	endtask

	task automatic readback_registers();
		reg_bus_pkg::reg_data_t cfg;
		reg_bus_pkg::reg_data_t offs_lo;
		reg_bus_pkg::reg_data_t offs_hi;
		reg_bus_pkg::reg_data_t width;
		reg_bus_pkg::reg_data_t got;
		repeat (3) begin
			cfg     = 8'(next_random());
			offs_lo = 8'(next_random());
			offs_hi = 8'(next_random());
			width   = 8'(next_random());
			set_addr(reg_bus_pkg::ADDR_TRIG_CFG);
			write_byte(cfg);
			set_addr(reg_bus_pkg::ADDR_GLITCH_OFFSET);
			write_byte(offs_lo); // low byte first
			write_byte(offs_hi);
			set_addr(reg_bus_pkg::ADDR_GLITCH_WIDTH);
			write_byte(width);
			set_addr(reg_bus_pkg::ADDR_TRIG_CFG);
			read_byte(got);
			compare_byte("TRIG_CFG", cfg & 8'h1f, got); // 5 defined bits
			set_addr(reg_bus_pkg::ADDR_GLITCH_OFFSET);
			read_byte(got);
			compare_byte("GLITCH_OFFSET[7:0]", offs_lo, got);
			read_byte(got);
			compare_byte("GLITCH_OFFSET[15:8]", offs_hi, got);
			set_addr(reg_bus_pkg::ADDR_GLITCH_WIDTH);
			read_byte(got);
			compare_byte("GLITCH_WIDTH", width, got);
		end
		// write with the chip deselected must not land
		set_addr(reg_bus_pkg::ADDR_GLITCH_WIDTH);
		select_chip(1'b0);
		write_byte(~width);
		select_chip(1'b1);
		set_addr(reg_bus_pkg::ADDR_GLITCH_WIDTH);
		read_byte(got);
		compare_byte("GLITCH_WIDTH after CEn high write", width, got);
	endtask

	// count starts from zero since io was idle until now
	task automatic count_trigger_edges();
		int unsigned n;
		reg_bus_pkg::reg_data_t lo;
		reg_bus_pkg::reg_data_t hi;
		n = 260 + next_random() % 20;
		set_addr(reg_bus_pkg::ADDR_TRIG_CFG);
		write_byte(8'h01); // io1 only, OR mode
		repeat (n) begin
			target_io_i = 4'(next_random()) | 4'b0001;
			step(2);
			target_io_i = 4'(next_random()) & 4'b1110; // masked lines stay noisy
			step(2);
		end
		step(2);
		set_addr(reg_bus_pkg::ADDR_TRIG_COUNT);
		read_byte(lo);
		read_byte(hi);
		compare_byte("TRIG_COUNT[7:0]", 8'(n), lo);
		compare_byte("TRIG_COUNT[15:8]", 8'(n >> 8), hi);
	endtask

	task automatic sweep_combine_modes();
		reg_bus_pkg::reg_data_t cfg;
		for (int r = 0; r < 10; r++) begin
			cfg = {3'b000, 1'(r % 2), 4'(next_random())};
			if (r < 2)
				cfg[3:0] = 4'h0; // zero mask in both modes
			set_addr(reg_bus_pkg::ADDR_TRIG_CFG);
			write_byte(cfg);
			repeat (16) begin
				target_io_i = 4'(next_random());
				step(1);
			end
		end
		target_io_i = '0;
		step(2);
	endtask

	task automatic pulse_io1();
		target_io_i = 4'(next_random()) | 4'b0001;
		step(3);
		target_io_i = 4'(next_random()) & 4'b1110;
		step(2);
	endtask

	task automatic run_shot(input int unsigned off, input int unsigned w);
		reg_bus_pkg::reg_data_t got;
		set_addr(reg_bus_pkg::ADDR_GLITCH_OFFSET);
		write_byte(8'(off));
		write_byte(8'(off >> 8));
		set_addr(reg_bus_pkg::ADDR_GLITCH_WIDTH);
		write_byte(8'(w));
		set_addr(reg_bus_pkg::ADDR_GLITCH_CTRL);
		write_byte(8'h01);
		compare_byte("armed_led_o", 8'h01, 8'(armed_led_o));
		set_addr(reg_bus_pkg::ADDR_GLITCH_CTRL);
		read_byte(got);
		compare_byte("GLITCH_CTRL armed", 8'h01, got);
		pulse_io1();
		step(off + w + 4); // pulse timing itself is checked by capture_chk
		compare_byte("armed_led_o after shot", 8'h00, 8'(armed_led_o));
		set_addr(reg_bus_pkg::ADDR_GLITCH_CTRL);
		read_byte(got);
		compare_byte("GLITCH_CTRL after shot", 8'h00, got);
		pulse_io1(); // not re-armed, no pulse expected
		step(off + w + 4);
	endtask

	task automatic fire_glitch_shots();
		set_addr(reg_bus_pkg::ADDR_TRIG_CFG);
		write_byte(8'h01);
		target_io_i = '0;
		step(2);
		run_shot(0, 1 + next_random() % 12);
		run_shot(1 + next_random() % 47, 1 + next_random() % 12);
		run_shot(256 + next_random() % 16, 1 + next_random() % 12); // offset high byte
		run_shot(next_random() % 16, 0);
	endtask

	always @(posedge clk_usb) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
		if (DUT.u_chk.fail_count != 0) begin
			$display("an assertion in capture_chk failed");
			stop_with_failure();
		end
	end

	initial begin
		clk_usb     = 1'b0;
		arst_n_i    = 1'b0;
		usb_addr_i  = '0;
		usb_data_i  = '0;
		usb_rdn_i   = 1'b1;
		usb_wrn_i   = 1'b1;
		usb_cen_i   = 1'b1;
		usb_alen_i  = 1'b1;
		target_io_i = '0;
		rng_state   = 32'h3f2b;
		repeat (8) @(posedge clk_usb);
		#2;
		arst_n_i = 1'b1;
		step(2);
		select_chip(1'b1);
		readback_registers();
		count_trigger_edges();
		sweep_combine_modes();
		fire_glitch_shots();
		step(4);
		if (DUT.u_chk.fail_count != 0) begin
			$display("an assertion in capture_chk failed");
			stop_with_failure();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== capture_chk.sv ====
// assertion checker for the capture top covering trigger combine, glitch timing and bus enable
`timescale 1ns/100ps
`default_nettype none

module capture_chk (
	input wire                              clk_usb,
	input wire                              arst_n_i,
	input wire [3:0]                        target_io_i,
	input wire                              trigger_i,
	input wire                              glitch_i,
	input wire                              armed_i,
	input wire                              data_oe_i,
	input wire                              rdn_sync_i,
	input wire                              rd_pulse_i,
	input wire capture_pkg::trig_cfg_t      cfg_i,
	input wire capture_pkg::glitch_offset_t offset_i,
	input wire capture_pkg::glitch_width_t  width_i
);

	int unsigned fail_count = 0; // polled by the testbench

	logic        trig_exp;
	logic        trig_d_q;
	logic        shot_q;     // pulse pending or running
	int unsigned age_q;      // cycles since the armed edge
	int unsigned first_q;
	int unsigned last_q;
	logic        glitch_exp;

	always_comb begin
		if (cfg_i.and_mode)
			trig_exp = (cfg_i.mask != '0) && ((target_io_i & cfg_i.mask) == cfg_i.mask);
		else
			trig_exp = (target_io_i & cfg_i.mask) != '0;
	end

	// expected window t+offset+1 .. t+offset+width
	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			trig_d_q <= 1'b0;
			shot_q   <= 1'b0;
			age_q    <= 0;
			first_q  <= 0;
			last_q   <= 0;
		end else begin
			trig_d_q <= trigger_i;
			if (trigger_i && !trig_d_q && armed_i && width_i != '0) begin
				shot_q  <= 1'b1;
				age_q   <= 1;
				first_q <= 32'(offset_i) + 32'd1;
				last_q  <= 32'(offset_i) + 32'(width_i);
			end else if (shot_q) begin
				age_q <= age_q + 1;
				if (age_q >= last_q)
					shot_q <= 1'b0;
			end
		end
	end

	assign glitch_exp = shot_q && age_q >= first_q && age_q <= last_q;

	a_trig_combine: assert property (@(posedge clk_usb) disable iff (!arst_n_i)
		trigger_i == $past(trig_exp))
	else begin
		fail_count = fail_count + 1;
		$error("trigger_o does not follow the masked io lines of the previous cycle");
	end

	a_glitch_window: assert property (@(posedge clk_usb) disable iff (!arst_n_i)
		glitch_i == glitch_exp)
	else begin
		fail_count = fail_count + 1;
		$error("glitch_o outside the armed offset and width window");
	end

	a_disarm: assert property (@(posedge clk_usb) disable iff (!arst_n_i)
		$fell(glitch_i) |-> !armed_i)
	else begin
		fail_count = fail_count + 1;
		$error("still armed after the glitch pulse");
	end

	// enable only while RDn is low, and only from a read pulse on
	a_oe_rdn: assert property (@(posedge clk_usb) disable iff (!arst_n_i)
		data_oe_i |-> !rdn_sync_i && ($past(rd_pulse_i) || $past(data_oe_i)))
	else begin
		fail_count = fail_count + 1;
		$error("data output enable high while RDn is high or without a read");
	end

	a_oe_read: assert property (@(posedge clk_usb) disable iff (!arst_n_i)
		rd_pulse_i |=> data_oe_i)
	else begin
		fail_count = fail_count + 1;
		$error("data output enable not raised in the cycle after a read");
	end

	a_reset_vals: assert property (@(posedge clk_usb)
		(!arst_n_i || $rose(arst_n_i)) |-> (!data_oe_i && !glitch_i && !trigger_i && !armed_i))
	else begin
		fail_count = fail_count + 1;
		$error("outputs not cleared by reset");
	end

endmodule

bind capture_top capture_chk u_chk (
	.clk_usb     (clk_usb),
	.arst_n_i    (arst_n_i),
	.target_io_i (target_io_i),
	.trigger_i   (trigger_o),
	.glitch_i    (glitch_o),
	.armed_i     (armed_led_o),
	.data_oe_i   (usb_data_oe_o),
	.rdn_sync_i  (u_bridge.strobe_s[0]),
	.rd_pulse_i  (reg_req.read),
	.cfg_i       (u_trigger.cfg_q),
	.offset_i    (u_glitch.offset_q),
	.width_i     (u_glitch.width_q)
);

`default_nettype wire

// ==== capture_top.sv ====
// capture front end top joining the host bridge, trigger controller and glitch generator
`timescale 1ns/100ps
`default_nettype none

module capture_top (
	input  wire                         clk_usb,
	input  wire                         arst_n_i,
	input  wire [7:0]                   usb_addr_i,
	input  wire reg_bus_pkg::reg_data_t usb_data_i,
	output reg_bus_pkg::reg_data_t      usb_data_o,
	output logic                        usb_data_oe_o,
	input  wire                         usb_rdn_i,
	input  wire                         usb_wrn_i,
	input  wire                         usb_cen_i,
	input  wire                         usb_alen_i,
	input  wire [3:0]                   target_io_i,
	output logic                        trigger_o,
	output logic                        glitch_o,
	output logic                        armed_led_o
);

	reg_bus_pkg::reg_req_t reg_req;
	reg_bus_pkg::reg_rsp_t trig_rsp;
	reg_bus_pkg::reg_rsp_t glitch_rsp;

	host_bus_bridge u_bridge (
		.clk_usb       (clk_usb),
		.arst_n_i      (arst_n_i),
		.usb_addr_i    (usb_addr_i),
		.usb_data_i    (usb_data_i),
		.usb_data_o    (usb_data_o),
		.usb_data_oe_o (usb_data_oe_o),
		.usb_rdn_i     (usb_rdn_i),
		.usb_wrn_i     (usb_wrn_i),
		.usb_cen_i     (usb_cen_i),
		.usb_alen_i    (usb_alen_i),
		.req_o         (reg_req),
		.rdata_i       (trig_rsp.rdata | glitch_rsp.rdata) // peers are zero off their range
	);

	trigger_ctrl u_trigger (
		.clk_usb     (clk_usb),
		.arst_n_i    (arst_n_i),
		.req_i       (reg_req),
		.rsp_o       (trig_rsp),
		.target_io_i (target_io_i),
		.trigger_o   (trigger_o)
	);

	glitch_gen u_glitch (
		.clk_usb   (clk_usb),
		.arst_n_i  (arst_n_i),
		.req_i     (reg_req),
		.rsp_o     (glitch_rsp),
		.trigger_i (trigger_o),
		.glitch_o  (glitch_o),
		.armed_o   (armed_led_o)
	);

endmodule

`default_nettype wire

// ==== glitch_gen.sv ====
// glitch generator that fires a pulse of set width a set offset after an armed trigger edge
`timescale 1ns/100ps
`default_nettype none

module glitch_gen (
	input  wire                        clk_usb,
	input  wire                        arst_n_i,
	input  wire reg_bus_pkg::reg_req_t req_i,
	output reg_bus_pkg::reg_rsp_t      rsp_o,
	input  wire                        trigger_i,
	output logic                       glitch_o,
	output logic                       armed_o
);

	capture_pkg::glitch_state_e  state_q;
	capture_pkg::glitch_offset_t offset_q;
	capture_pkg::glitch_width_t  width_q;
	capture_pkg::glitch_offset_t cnt_q;   // shared by offset and width phases
	capture_pkg::glitch_offset_t width_ext;
	logic trig_d;
	logic trig_rise;
	logic offs_sel;
	logic width_sel;
	logic ctrl_sel;
	logic arm_wr;

	assign offs_sel  = req_i.addrvalid && (req_i.addr == reg_bus_pkg::ADDR_GLITCH_OFFSET);
	assign width_sel = req_i.addrvalid && (req_i.addr == reg_bus_pkg::ADDR_GLITCH_WIDTH);
	assign ctrl_sel  = req_i.addrvalid && (req_i.addr == reg_bus_pkg::ADDR_GLITCH_CTRL);
	assign arm_wr    = req_i.write && ctrl_sel && req_i.bytecnt == '0;

	assign trig_rise = trigger_i & ~trig_d;
	assign width_ext = capture_pkg::glitch_offset_t'(width_q);
	assign armed_o   = (state_q == capture_pkg::G_ARMED);

	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			offset_q <= '0;
			width_q  <= '0;
		end else if (req_i.write) begin
			if (offs_sel && req_i.bytecnt == 4'd0)
				offset_q[7:0] <= req_i.wdata; // little endian
			if (offs_sel && req_i.bytecnt == 4'd1)
				offset_q[15:8] <= req_i.wdata;
			if (width_sel && req_i.bytecnt == 4'd0)
				width_q <= req_i.wdata;
		end
	end

	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q  <= capture_pkg::G_IDLE;
			cnt_q    <= '0;
			glitch_o <= 1'b0;
			trig_d   <= 1'b0;
		end else begin
			trig_d <= trigger_i;
			case (state_q)
				capture_pkg::G_IDLE: begin
					if (arm_wr && req_i.wdata[0])
						state_q <= capture_pkg::G_ARMED;
				end
				capture_pkg::G_ARMED: begin
					cnt_q <= capture_pkg::glitch_offset_t'(1);
					if (trig_rise) begin
						if (width_q == '0) begin
							state_q <= capture_pkg::G_IDLE; // zero width fires nothing
						end else if (offset_q == '0) begin
							state_q  <= capture_pkg::G_PULSE;
							glitch_o <= 1'b1;
						end else begin
							state_q <= capture_pkg::G_WAIT;
						end
					end else if (arm_wr && !req_i.wdata[0]) begin
						state_q <= capture_pkg::G_IDLE; // disarm from host
					end
				end
				capture_pkg::G_WAIT: begin
					if (cnt_q >= offset_q) begin
						state_q  <= capture_pkg::G_PULSE;
						glitch_o <= 1'b1;
						cnt_q    <= capture_pkg::glitch_offset_t'(1);
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				capture_pkg::G_PULSE: begin
					if (cnt_q >= width_ext) begin
						state_q  <= capture_pkg::G_IDLE; // arm cleared until the host re-arms
						glitch_o <= 1'b0;
					end else begin
						cnt_q <= cnt_q + 1'b1;
					end
				end
				default: state_q <= capture_pkg::G_IDLE;
			endcase
		end
	end

	always_comb begin
		rsp_o.rdata = '0;
		if (offs_sel && req_i.bytecnt == 4'd0)
			rsp_o.rdata = offset_q[7:0];
		else if (offs_sel && req_i.bytecnt == 4'd1)
			rsp_o.rdata = offset_q[15:8];
		else if (width_sel && req_i.bytecnt == 4'd0)
			rsp_o.rdata = width_q;
		else if (ctrl_sel && req_i.bytecnt == 4'd0)
			rsp_o.rdata = {7'b0000000, armed_o}; // arm reads back the live state
	end

endmodule

`default_nettype wire

// ==== trigger_ctrl.sv ====
// trigger controller that masks and combines the target io lines and counts trigger edges
`timescale 1ns/100ps
`default_nettype none

module trigger_ctrl (
	input  wire                        clk_usb,
	input  wire                        arst_n_i,
	input  wire reg_bus_pkg::reg_req_t req_i,
	output reg_bus_pkg::reg_rsp_t      rsp_o,
	input  wire [3:0]                  target_io_i,
	output logic                       trigger_o
);

	capture_pkg::trig_cfg_t   cfg_q;
	capture_pkg::trig_mask_t  masked;
	capture_pkg::trig_count_t count_q;
	logic trig_next;
	logic cfg_sel;
	logic cnt_sel;

	assign cfg_sel = req_i.addrvalid && (req_i.addr == reg_bus_pkg::ADDR_TRIG_CFG);
	assign cnt_sel = req_i.addrvalid && (req_i.addr == reg_bus_pkg::ADDR_TRIG_COUNT);
	assign masked  = target_io_i & cfg_q.mask;

	always_comb begin
		if (cfg_q.mask == '0)
			trig_next = 1'b0; // nothing enabled
		else if (cfg_q.and_mode)
			trig_next = &(target_io_i | ~cfg_q.mask); // disabled lines count as high
		else
			trig_next = |masked;
	end

	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cfg_q <= '0;
		end else if (req_i.write && cfg_sel && req_i.bytecnt == '0) begin
			cfg_q <= capture_pkg::trig_cfg_t'(req_i.wdata[$bits(capture_pkg::trig_cfg_t)-1:0]);
		end
	end

	// counter steps on the same edge that raises trigger_o
	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			trigger_o <= 1'b0;
			count_q   <= '0;
		end else begin
			trigger_o <= trig_next;
			if (trig_next && !trigger_o)
				count_q <= count_q + 1'b1; // wraps
		end
	end

	always_comb begin
		rsp_o.rdata = '0;
		if (cfg_sel && req_i.bytecnt == '0) begin
			rsp_o.rdata = {3'b000, cfg_q};
		end else if (cnt_sel) begin
			case (req_i.bytecnt)
				4'd0:    rsp_o.rdata = count_q[7:0];
				4'd1:    rsp_o.rdata = count_q[15:8];
				default: rsp_o.rdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== host_bus_bridge.sv ====
// host bridge that synchronizes the host strobe bus and turns it into register bus requests
`timescale 1ns/100ps
`default_nettype none

module host_bus_bridge (
	input  wire                         clk_usb,
	input  wire                         arst_n_i,
	input  wire [7:0]                   usb_addr_i,
	input  wire reg_bus_pkg::reg_data_t usb_data_i,
	output reg_bus_pkg::reg_data_t      usb_data_o,
	output logic                        usb_data_oe_o,
	input  wire                         usb_rdn_i,
	input  wire                         usb_wrn_i,
	input  wire                         usb_cen_i,
	input  wire                         usb_alen_i,
	output reg_bus_pkg::reg_req_t       req_o,
	input  wire reg_bus_pkg::reg_data_t rdata_i
);

	// strobe bit 3 alen, 2 cen, 1 wrn, 0 rdn
	logic [3:0] strobe_n;
	logic [reg_bus_pkg::SYNC_STAGES-1:0][3:0] sync_q;
	logic [3:0] strobe_s;  // synchronized, still active low
	logic [3:0] strobe_d;  // one cycle older
	logic [3:0] fall;

	reg_bus_pkg::reg_addr_t addr_q;
	reg_bus_pkg::bytecnt_t  bcnt_q;
	reg_bus_pkg::reg_data_t wdata_q;
	logic rd_q;
	logic wr_q;
	logic oe_q;

	assign strobe_n = {usb_alen_i, usb_cen_i, usb_wrn_i, usb_rdn_i};
	assign strobe_s = sync_q[reg_bus_pkg::SYNC_STAGES-1];
	assign fall     = strobe_d & ~strobe_s;

	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync_q   <= '1; // strobes idle high
			strobe_d <= '1;
		end else begin
			sync_q   <= {sync_q[reg_bus_pkg::SYNC_STAGES-2:0], strobe_n};
			strobe_d <= strobe_s;
		end
	end

	// strobe pulses land on the third edge that sees the strobe low
	always_ff @(posedge clk_usb or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_q   <= 1'b0;
			wr_q   <= 1'b0;
			addr_q <= '0;
			bcnt_q <= '0;
			oe_q   <= 1'b0;
		end else begin
			rd_q <= fall[0] & ~strobe_s[2]; // no access while CEn high
			wr_q <= fall[1] & ~strobe_s[2];

			if (fall[3]) begin
				addr_q <= usb_addr_i[reg_bus_pkg::ADDR_W-1:0];
				bcnt_q <= '0;
			end else if (rd_q || wr_q) begin
				bcnt_q <= bcnt_q + 1'b1; // next byte of a multi-byte register
			end

			if (rd_q)
				oe_q <= 1'b1;
			else if (strobe_s[0])
				oe_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_usb) begin
		if (fall[1])
			wdata_q <= usb_data_i; // captured along with the write pulse
		if (rd_q)
			usb_data_o <= rdata_i;
	end

	// drop the enable as soon as RDn is seen high again
	assign usb_data_oe_o = oe_q & ~strobe_s[0];

	assign req_o = '{
		addr:      addr_q,
		bytecnt:   bcnt_q,
		wdata:     wdata_q,
		read:      rd_q,
		write:     wr_q,
		addrvalid: ~strobe_s[2]
	};

endmodule

`default_nettype wire

// ==== capture_pkg.sv ====
// capture package with trigger and glitch types and the glitch generator states
`default_nettype none

package capture_pkg;

	localparam int TRIG_IO_N      = 4;
	localparam int TRIG_COUNT_W   = 16;
	localparam int GLITCH_OFFS_W  = 16;
	localparam int GLITCH_WIDTH_W = 8;

	typedef logic [TRIG_IO_N-1:0]      trig_mask_t;     // io1 in bit 0
	typedef logic [TRIG_COUNT_W-1:0]   trig_count_t;
	typedef logic [GLITCH_OFFS_W-1:0]  glitch_offset_t; // cycles after trigger
	typedef logic [GLITCH_WIDTH_W-1:0] glitch_width_t;  // pulse cycles

	typedef enum logic [1:0] {
		G_IDLE  = 2'd0,
		G_ARMED = 2'd1,
		G_WAIT  = 2'd2, // counting the offset
		G_PULSE = 2'd3
	} glitch_state_e;

	// and_mode lands in bit 4, mask in bits 3..0
	typedef struct packed {
		logic       and_mode;
		trig_mask_t mask;
	} trig_cfg_t;

endpackage

`default_nettype wire

// ==== reg_bus_pkg.sv ====
// register bus package with widths, request and response structs and the register address map
`default_nettype none

package reg_bus_pkg;

	localparam int ADDR_W = 6;
	localparam int DATA_W = 8;
	localparam int BCNT_W = 4;

	// strobe synchronizer depth
	localparam int SYNC_STAGES = 2;

	typedef logic [ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] reg_data_t;
	typedef logic [BCNT_W-1:0] bytecnt_t; // byte index within a register

	// request from the bridge, seen by every peer
	typedef struct packed {
		reg_addr_t addr;
		bytecnt_t  bytecnt;
		reg_data_t wdata;
		logic      read;      // single cycle
		logic      write;     // single cycle
		logic      addrvalid; // chip enable held low
	} reg_req_t;

	// peers drive zero outside their own addresses
	typedef struct packed {
		reg_data_t rdata;
	} reg_rsp_t;

	// trigger controller
	localparam reg_addr_t ADDR_TRIG_CFG   = 6'd8;
	localparam reg_addr_t ADDR_TRIG_COUNT = 6'd9;  // 2 bytes, read only

	// glitch generator
	localparam reg_addr_t ADDR_GLITCH_OFFSET = 6'd16; // 2 bytes
	localparam reg_addr_t ADDR_GLITCH_WIDTH  = 6'd17;
	localparam reg_addr_t ADDR_GLITCH_CTRL   = 6'd18; // bit 0 arm

endpackage

`default_nettype wire
